// ==== verilog/rom_pkg.sv ====
package rom_pkg;

    // SDRAM word address and read beat
    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] sdram_data_t;

    // Byte address as seen by the loader
    typedef logic [24:0] ioctl_addr_t;

    // Read slot index
    typedef logic [1:0]  slot_sel_t;

    localparam slot_sel_t SLOT_MAIN = 2'd0;
    localparam slot_sel_t SLOT_OBJ  = 2'd1;
    localparam slot_sel_t SLOT_SCR  = 2'd2;

    // Request sequence towards the SDRAM controller
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_t;

endpackage

// ==== verilog/dwnld_decode.sv ====
`timescale 1ns/1ps

module dwnld_decode import rom_pkg::*; #(
    parameter sdram_addr_t SCR_START  = 22'h004000,
    parameter sdram_addr_t OBJ_START  = 22'h006000,
    parameter ioctl_addr_t PROM_START = 25'h001c000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output sdram_addr_t prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    output logic        prom_we
);

    logic [23:0] word_addr;
    logic        is_prom;
    logic        in_scr;
    logic        in_obj;
    sdram_addr_t swz_addr;
    sdram_addr_t prom_offset;
    logic        byte_wr;

    assign byte_wr     = downloading && ioctl_wr;
    assign word_addr   = ioctl_addr[24:1];
    assign is_prom     = ioctl_addr >= PROM_START;
    assign in_scr      = word_addr >= 24'(SCR_START) && word_addr < 24'(OBJ_START);
    assign in_obj      = word_addr >= 24'(OBJ_START) && !is_prom;
    assign prom_offset = sdram_addr_t'(ioctl_addr - PROM_START);

    // Tile and sprite ROMs sit in SDRAM with their low address lines reordered
    always_comb begin
        swz_addr = word_addr[21:0];
        if (in_scr) begin
            swz_addr[0]   = ~word_addr[3];
            swz_addr[3:1] = word_addr[2:0];
        end else if (in_obj) begin
            swz_addr[0]   = ~word_addr[3];
            swz_addr[1]   = ~word_addr[4];
            swz_addr[5:2] = {word_addr[5], word_addr[2:0]};
        end
    end

    // Write strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;
            if (prog_we && sdram_ack) begin
                prog_we <= 1'b0;
            end
            if (byte_wr) begin
                if (is_prom) begin
                    prom_we <= 1'b1;
                end else begin
                    prog_we <= 1'b1;
                end
            end
        end
    end

    // Byte lane select is active low, odd bytes go to the high lane
    always_ff @(posedge clk) begin
        if (byte_wr) begin
            prog_data <= ioctl_dout;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            // PROMs are addressed from their own base
            prog_addr <= is_prom ? prom_offset : swz_addr;
        end
    end

endmodule

// ==== verilog/rom_req_arbiter.sv ====
`timescale 1ns/1ps

module rom_req_arbiter import rom_pkg::*; #(
    parameter sdram_addr_t SCR_START = 22'h004000,
    parameter sdram_addr_t OBJ_START = 22'h006000,
    parameter int          MAIN_AW   = 15,
    parameter int          OBJ_AW    = 14,
    parameter int          SCR_AW    = 13
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               downloading,
    input  logic [2:0]         slot_miss,
    input  logic [MAIN_AW-1:0] main_addr,
    input  logic [OBJ_AW-1:0]  obj_addr,
    input  logic [SCR_AW-1:0]  scr_addr,
    input  logic               sdram_ack,
    input  logic               data_rdy,
    output logic               sdram_req,
    output sdram_addr_t        sdram_addr,
    output slot_sel_t          grant_sel,
    output logic               grant_valid
);

    arb_state_t  state;
    slot_sel_t   next_sel;
    sdram_addr_t next_addr;

    // Fixed priority, main first
    always_comb begin
        if (slot_miss[SLOT_MAIN]) begin
            next_sel = SLOT_MAIN;
        end else if (slot_miss[SLOT_OBJ]) begin
            next_sel = SLOT_OBJ;
        end else begin
            next_sel = SLOT_SCR;
        end
    end

    // Word address in SDRAM for the chosen client
    always_comb begin
        case (next_sel)
            SLOT_OBJ: next_addr = OBJ_START + sdram_addr_t'({obj_addr, 1'b0});
            SLOT_SCR: next_addr = SCR_START + sdram_addr_t'(scr_addr);
            default:  next_addr = sdram_addr_t'(main_addr >> 1);
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ARB_IDLE;
            sdram_req <= 1'b0;
            grant_sel <= SLOT_MAIN;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // No reads while the ROM contents are being loaded
                    if (!downloading && |slot_miss) begin
                        state     <= ARB_WAIT_ACK;
                        sdram_req <= 1'b1;
                        grant_sel <= next_sel;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= data_rdy ? ARB_IDLE : ARB_WAIT_DATA;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state     <= ARB_IDLE;
                    sdram_req <= 1'b0;
                end
            endcase
        end
    end

    // Address only moves while idle, so it is stable for the whole request
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            sdram_addr <= next_addr;
        end
    end

    assign grant_valid = state != ARB_IDLE;

endmodule

// ==== verilog/rom_slot_cache.sv ====
`timescale 1ns/1ps

module rom_slot_cache import rom_pkg::*; #(
    parameter int MAIN_AW = 15,
    parameter int OBJ_AW  = 14,
    parameter int SCR_AW  = 13
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               downloading,
    input  logic               main_cs,
    input  logic [MAIN_AW-1:0] main_addr,
    input  logic               obj_cs,
    input  logic [OBJ_AW-1:0]  obj_addr,
    input  logic               scr_cs,
    input  logic [SCR_AW-1:0]  scr_addr,
    input  slot_sel_t          grant_sel,
    input  logic               grant_valid,
    input  logic               data_dst,
    input  logic               data_rdy,
    input  sdram_data_t        data_read,
    output logic [2:0]         slot_miss,
    output logic               main_ok,
    output logic [7:0]         main_data,
    output logic               obj_ok,
    output logic [31:0]        obj_data,
    output logic               scr_ok,
    output logic [15:0]        scr_data
);

    logic [2:0]         valid;
    logic [2:0]         hit;
    logic               dwn_q;
    logic               beat_hi;
    logic [MAIN_AW-1:0] main_tag;
    logic [OBJ_AW-1:0]  obj_tag;
    logic [SCR_AW-1:0]  scr_tag;
    sdram_data_t        main_word;

    assign hit[SLOT_MAIN] = valid[SLOT_MAIN] && main_tag == main_addr;
    assign hit[SLOT_OBJ]  = valid[SLOT_OBJ]  && obj_tag  == obj_addr;
    assign hit[SLOT_SCR]  = valid[SLOT_SCR]  && scr_tag  == scr_addr;

    assign slot_miss = {scr_cs & ~hit[SLOT_SCR], obj_cs & ~hit[SLOT_OBJ],
                        main_cs & ~hit[SLOT_MAIN]};

    assign main_ok = main_cs & hit[SLOT_MAIN];
    assign obj_ok  = obj_cs  & hit[SLOT_OBJ];
    assign scr_ok  = scr_cs  & hit[SLOT_SCR];

    // Byte lane picked by the low address bit
    assign main_data = main_addr[0] ? main_word[15:8] : main_word[7:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid   <= 3'b000;
            dwn_q   <= 1'b0;
            beat_hi <= 1'b0;
        end else begin
            dwn_q <= downloading;
            if (grant_valid && data_dst) begin
                beat_hi <= ~beat_hi;
            end
            if (data_rdy || !grant_valid) begin
                beat_hi <= 1'b0;
            end
            if (grant_valid && data_rdy && !downloading) begin
                valid[grant_sel] <= 1'b1;
            end
            // New ROM contents on the way
            if (downloading && !dwn_q) begin
                valid <= 3'b000;
            end
        end
    end

    // Beat capture and address tags
    always_ff @(posedge clk) begin
        if (grant_valid && data_dst) begin
            case (grant_sel)
                SLOT_MAIN: main_word <= data_read;
                SLOT_SCR:  scr_data  <= data_read;
                SLOT_OBJ: begin
                    // Low half arrives first
                    if (beat_hi) begin
                        obj_data[31:16] <= data_read;
                    end else begin
                        obj_data[15:0] <= data_read;
                    end
                end
                default: begin
                end
            endcase
        end
        if (grant_valid && data_rdy) begin
            case (grant_sel)
                SLOT_MAIN: main_tag <= main_addr;
                SLOT_OBJ:  obj_tag  <= obj_addr;
                SLOT_SCR:  scr_tag  <= scr_addr;
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== verilog/rom_subsys_top.sv ====
`timescale 1ns/1ps

module rom_subsys_top import rom_pkg::*; #(
    parameter sdram_addr_t SCR_START  = 22'h004000,
    parameter sdram_addr_t OBJ_START  = 22'h006000,
    parameter ioctl_addr_t PROM_START = 25'h001c000,
    parameter int          MAIN_AW    = 15,
    parameter int          OBJ_AW     = 14,
    parameter int          SCR_AW     = 13
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               downloading,
    // Loader
    input  ioctl_addr_t        ioctl_addr,
    input  logic [7:0]         ioctl_dout,
    input  logic               ioctl_wr,
    output sdram_addr_t        prog_addr,
    output logic [7:0]         prog_data,
    output logic [1:0]         prog_mask,
    output logic               prog_we,
    output logic               prom_we,
    // ROM clients
    input  logic               main_cs,
    input  logic [MAIN_AW-1:0] main_addr,
    output logic               main_ok,
    output logic [7:0]         main_data,
    input  logic               obj_cs,
    input  logic [OBJ_AW-1:0]  obj_addr,
    output logic               obj_ok,
    output logic [31:0]        obj_data,
    input  logic               scr_cs,
    input  logic [SCR_AW-1:0]  scr_addr,
    output logic               scr_ok,
    output logic [15:0]        scr_data,
    // SDRAM controller
    output logic               sdram_req,
    output sdram_addr_t        sdram_addr,
    input  logic               sdram_ack,
    input  logic               data_dst,
    input  logic               data_rdy,
    input  sdram_data_t        data_read
);

    logic [2:0] slot_miss;
    slot_sel_t  grant_sel;
    logic       grant_valid;

    dwnld_decode #(
        .SCR_START  ( SCR_START  ),
        .OBJ_START  ( OBJ_START  ),
        .PROM_START ( PROM_START )
    ) u_decode (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    rom_req_arbiter #(
        .SCR_START ( SCR_START ),
        .OBJ_START ( OBJ_START ),
        .MAIN_AW   ( MAIN_AW   ),
        .OBJ_AW    ( OBJ_AW    ),
        .SCR_AW    ( SCR_AW    )
    ) u_arbiter (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .slot_miss   ( slot_miss   ),
        .main_addr   ( main_addr   ),
        .obj_addr    ( obj_addr    ),
        .scr_addr    ( scr_addr    ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .grant_sel   ( grant_sel   ),
        .grant_valid ( grant_valid )
    );

    rom_slot_cache #(
        .MAIN_AW ( MAIN_AW ),
        .OBJ_AW  ( OBJ_AW  ),
        .SCR_AW  ( SCR_AW  )
    ) u_cache (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .main_cs     ( main_cs     ),
        .main_addr   ( main_addr   ),
        .obj_cs      ( obj_cs      ),
        .obj_addr    ( obj_addr    ),
        .scr_cs      ( scr_cs      ),
        .scr_addr    ( scr_addr    ),
        .grant_sel   ( grant_sel   ),
        .grant_valid ( grant_valid ),
        .data_dst    ( data_dst    ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .slot_miss   ( slot_miss   ),
        .main_ok     ( main_ok     ),
        .main_data   ( main_data   ),
        .obj_ok      ( obj_ok      ),
        .obj_data    ( obj_data    ),
        .scr_ok      ( scr_ok      ),
        .scr_data    ( scr_data    )
    );

endmodule

// ==== sim/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model import rom_pkg::*; #(
    parameter sdram_addr_t OBJ_START = 22'h006000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        sdram_req,
    input  sdram_addr_t sdram_addr,
    input  logic        prog_we,
    output logic        sdram_ack,
    output logic        data_dst,
    output logic        data_rdy,
    output sdram_data_t data_read
);

    integer      seed;
    int          delay;
    int          beats;
    logic        is_read;
    sdram_addr_t req_addr;
    sdram_addr_t beat_addr;

    // Everything moves 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed      = 32'hf6b4;
        sdram_ack = 1'b0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            next_cycle();
            if (arst_n && (sdram_req || prog_we)) begin
                is_read  = sdram_req;
                req_addr = sdram_addr;
                delay    = int'($unsigned($random(seed)) % 32'd6);
                repeat (delay) next_cycle();
                sdram_ack = 1'b1;
                next_cycle();
                sdram_ack = 1'b0;
                if (is_read) begin
                    // Sprite reads return two words
                    beats = (req_addr >= OBJ_START) ? 2 : 1;
                    delay = int'($unsigned($random(seed)) % 32'd6);
                    repeat (delay) next_cycle();
                    for (int i = 0; i < beats; i++) begin
                        beat_addr = req_addr + sdram_addr_t'(i);
                        data_dst  = 1'b1;
                        data_read = beat_addr[15:0] ^ 16'h5a5a;
                        data_rdy  = (i == beats - 1);
                        next_cycle();
                    end
                    data_dst = 1'b0;
                    data_rdy = 1'b0;
                end
            end
        end
    end

endmodule

// ==== sim/tb_rom_subsys.sv ====
`timescale 1ns/1ps

module tb_rom_subsys import rom_pkg::*; ();

    localparam sdram_addr_t SCR_START     = 22'h004000;
    localparam sdram_addr_t OBJ_START     = 22'h006000;
    localparam ioctl_addr_t PROM_START    = 25'h001c000;
    localparam int          MAIN_AW       = 15;
    localparam int          OBJ_AW        = 14;
    localparam int          SCR_AW        = 13;
    localparam int          CLK_NS        = 4;
    localparam int          WAIT_LIMIT    = 64;
    localparam int          TEST_REQUESTS = 23;

    logic               clk;
    logic               arst_n;
    logic               downloading;
    ioctl_addr_t        ioctl_addr;
    logic [7:0]         ioctl_dout;
    logic               ioctl_wr;
    sdram_addr_t        prog_addr;
    logic [7:0]         prog_data;
    logic [1:0]         prog_mask;
    logic               prog_we;
    logic               prom_we;
    logic               main_cs;
    logic [MAIN_AW-1:0] main_addr;
    logic               main_ok;
    logic [7:0]         main_data;
    logic               obj_cs;
    logic [OBJ_AW-1:0]  obj_addr;
    logic               obj_ok;
    logic [31:0]        obj_data;
    logic               scr_cs;
    logic [SCR_AW-1:0]  scr_addr;
    logic               scr_ok;
    logic [15:0]        scr_data;
    logic               sdram_req;
    sdram_addr_t        sdram_addr;
    logic               sdram_ack;
    logic               data_dst;
    logic               data_rdy;
    sdram_data_t        data_read;

    // Expected values, set by the stimulus before each transfer
    sdram_addr_t        exp_prog_addr;
    logic [7:0]         exp_prog_data;
    logic [1:0]         exp_prog_mask;
    logic               exp_is_prom;
    logic [7:0]         exp_main_data;
    logic [31:0]        exp_obj_data;
    logic [15:0]        exp_scr_data;
    logic               expect_hit;
    sdram_addr_t        exp_addrs [4];
    sdram_addr_t        exp_req_addr;
    int                 req_count;
    int                 req_base;
    integer             seed;
    int                 error_count;
    int                 test_count;
    int                 failed_tests;
    int                 test_err_base;

    rom_subsys_top #(
        .SCR_START ( SCR_START ), .OBJ_START ( OBJ_START ), .PROM_START ( PROM_START ),
        .MAIN_AW   ( MAIN_AW   ), .OBJ_AW    ( OBJ_AW    ), .SCR_AW     ( SCR_AW     )
    ) rom_subsys_top_inst (
        .clk ( clk ), .arst_n ( arst_n ), .downloading ( downloading ),
        .ioctl_addr ( ioctl_addr ), .ioctl_dout ( ioctl_dout ), .ioctl_wr ( ioctl_wr ),
        .prog_addr ( prog_addr ), .prog_data ( prog_data ), .prog_mask ( prog_mask ),
        .prog_we ( prog_we ), .prom_we ( prom_we ),
        .main_cs ( main_cs ), .main_addr ( main_addr ), .main_ok ( main_ok ),
        .main_data ( main_data ), .obj_cs ( obj_cs ), .obj_addr ( obj_addr ),
        .obj_ok ( obj_ok ), .obj_data ( obj_data ), .scr_cs ( scr_cs ),
        .scr_addr ( scr_addr ), .scr_ok ( scr_ok ), .scr_data ( scr_data ),
        .sdram_req ( sdram_req ), .sdram_addr ( sdram_addr ), .sdram_ack ( sdram_ack ),
        .data_dst ( data_dst ), .data_rdy ( data_rdy ), .data_read ( data_read )
    );

    sdram_model #(.OBJ_START ( OBJ_START )) sdram (
        .clk ( clk ), .arst_n ( arst_n ), .sdram_req ( sdram_req ),
        .sdram_addr ( sdram_addr ), .prog_we ( prog_we ), .sdram_ack ( sdram_ack ),
        .data_dst ( data_dst ), .data_rdy ( data_rdy ), .data_read ( data_read )
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Read requests seen by the SDRAM, used to pick the expected address
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_count <= 0;
        end else if (sdram_req && sdram_ack) begin
            req_count <= req_count + 1;
        end
    end

    assign exp_req_addr = exp_addrs[2'(req_count - req_base)];

    function automatic void report_mismatch(input string name, input logic [31:0] expected,
                                            input logic [31:0] seen);
        $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, seen);
        error_count++;
    endfunction

    function automatic void report_event(input string what);
        $display("Error at %0t: %s", $time, what);
        error_count++;
    endfunction

    // Reference model of the ROM contents and address maps
    function automatic sdram_data_t rom_word(input sdram_addr_t a);
        return a[15:0] ^ 16'h5a5a;
    endfunction

    function automatic sdram_addr_t main_word_addr(input logic [MAIN_AW-1:0] a);
        return sdram_addr_t'(a[MAIN_AW-1:1]);
    endfunction

    function automatic sdram_addr_t obj_word_addr(input logic [OBJ_AW-1:0] a);
        return OBJ_START + sdram_addr_t'({a, 1'b0});
    endfunction

    function automatic sdram_addr_t scr_word_addr(input logic [SCR_AW-1:0] a);
        return SCR_START + sdram_addr_t'(a);
    endfunction

    function automatic sdram_addr_t expected_prog_addr(input ioctl_addr_t a);
        sdram_addr_t w;
        w = a[22:1];
        if (w >= SCR_START && w < OBJ_START) begin
            return {w[21:4], w[2:0], ~w[3]};
        end else if (w >= OBJ_START && a < PROM_START) begin
            return {w[21:6], w[5], w[2:0], ~w[4], ~w[3]};
        end
        return w;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic load_byte(input ioctl_addr_t a);
        int cycles;
        cycles        = 0;
        ioctl_dout    = 8'($random(seed));
        ioctl_addr    = a;
        exp_is_prom   = a >= PROM_START;
        exp_prog_addr = expected_prog_addr(a);
        exp_prog_data = ioctl_dout;
        exp_prog_mask = a[0] ? 2'b01 : 2'b10;
        ioctl_wr      = 1'b1;
        step();
        ioctl_wr = 1'b0;
        if (exp_is_prom) begin
            step();
        end else begin
            // Loader holds off until the word write is acknowledged
            while (prog_we && cycles < WAIT_LIMIT) begin
                step();
                cycles++;
            end
            if (prog_we) begin
                report_event("prog_we never dropped after a byte write");
            end
        end
    endtask

    task automatic aim_reads(input logic [MAIN_AW-1:0] m, input logic [OBJ_AW-1:0] o,
                             input logic [SCR_AW-1:0] s);
        sdram_data_t w;
        main_addr     = m;
        obj_addr      = o;
        scr_addr      = s;
        w             = rom_word(main_word_addr(m));
        exp_main_data = m[0] ? w[15:8] : w[7:0];
        exp_obj_data  = {rom_word(obj_word_addr(o) + 22'd1), rom_word(obj_word_addr(o))};
        exp_scr_data  = rom_word(scr_word_addr(s));
    endtask

    task automatic expect_single(input sdram_addr_t a);
        exp_addrs[0] = a;
        req_base     = req_count;
    endtask

    // Raise cs on the selected slots and hold it until every one of them is ok
    task automatic run_reads(input logic [2:0] sel);
        logic [2:0] done;
        int         cycles;
        done    = 3'b000;
        cycles  = 0;
        main_cs = sel[0];
        obj_cs  = sel[1];
        scr_cs  = sel[2];
        while (done != sel && cycles < 3 * WAIT_LIMIT) begin
            step();
            cycles++;
            done = done | ({scr_ok, obj_ok, main_ok} & sel);
        end
        if (done != sel) begin
            report_event("read did not complete, ok flag never rose");
        end
        step();
        main_cs = 1'b0;
        obj_cs  = 1'b0;
        scr_cs  = 1'b0;
    endtask

    task automatic check_requests(input int n);
        assert (req_count - req_base == n)
            else report_mismatch("sdram_req count", 32'(n), 32'(req_count - req_base));
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_err_base) begin
            $display("test %0d %s: passed", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed", test_count, name);
        end
        test_err_base = error_count;
    endtask

    // Download path
    prog_addr_check: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |-> prog_addr == exp_prog_addr)
        else report_mismatch("prog_addr", 32'(exp_prog_addr), 32'(prog_addr));
    prog_data_check: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |-> prog_data == exp_prog_data)
        else report_mismatch("prog_data", 32'(exp_prog_data), 32'(prog_data));
    prog_mask_check: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |-> prog_mask == exp_prog_mask)
        else report_mismatch("prog_mask", 32'(exp_prog_mask), 32'(prog_mask));
    prog_we_rise: assert property (@(posedge clk) disable iff (!arst_n)
        downloading && ioctl_wr && !exp_is_prom |=> prog_we)
        else report_event("prog_we did not rise one cycle after ioctl_wr");
    prog_we_hold: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we && !sdram_ack |=> prog_we)
        else report_event("prog_we dropped before sdram_ack");
    prog_we_release: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we && sdram_ack |=> !prog_we)
        else report_event("prog_we stayed high after sdram_ack");
    prog_we_prom: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |-> !exp_is_prom)
        else report_event("prog_we raised for a PROM byte");
    prom_we_rise: assert property (@(posedge clk) disable iff (!arst_n)
        downloading && ioctl_wr && exp_is_prom |=> prom_we)
        else report_event("prom_we did not rise for a PROM byte");
    prom_we_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        prom_we |=> !prom_we)
        else report_event("prom_we longer than one cycle");
    prom_we_region: assert property (@(posedge clk) disable iff (!arst_n)
        prom_we |-> exp_is_prom)
        else report_event("prom_we raised for a byte below PROM_START");

    // Read path
    sdram_addr_check: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_req |-> sdram_addr == exp_req_addr)
        else report_mismatch("sdram_addr", 32'(exp_req_addr), 32'(sdram_addr));
    main_data_check: assert property (@(posedge clk) disable iff (!arst_n)
        main_ok |-> main_data == exp_main_data)
        else report_mismatch("main_data", 32'(exp_main_data), 32'(main_data));
    obj_data_check: assert property (@(posedge clk) disable iff (!arst_n)
        obj_ok |-> obj_data == exp_obj_data)
        else report_mismatch("obj_data", exp_obj_data, obj_data);
    scr_data_check: assert property (@(posedge clk) disable iff (!arst_n)
        scr_ok |-> scr_data == exp_scr_data)
        else report_mismatch("scr_data", 32'(exp_scr_data), 32'(scr_data));
    hit_ok_check: assert property (@(posedge clk) disable iff (!arst_n)
        expect_hit |-> {scr_ok, obj_ok, main_ok} == {scr_cs, obj_cs, main_cs})
        else report_mismatch("ok flags", 32'({scr_cs, obj_cs, main_cs}),
                             32'({scr_ok, obj_ok, main_ok}));
    hit_req_check: assert property (@(posedge clk) disable iff (!arst_n)
        expect_hit |-> !sdram_req)
        else report_event("sdram_req raised for a cached address");

    // Watchdog
    initial begin
        #(TEST_REQUESTS * WAIT_LIMIT * CLK_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed          = 32'hf6b4;
        error_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        test_err_base = 0;
        req_base      = 0;
        clk           = 1'b0;
        arst_n        = 1'b0;
        downloading   = 1'b0;
        ioctl_addr    = '0;
        ioctl_dout    = '0;
        ioctl_wr      = 1'b0;
        main_cs       = 1'b0;
        obj_cs        = 1'b0;
        scr_cs        = 1'b0;
        expect_hit    = 1'b0;
        exp_is_prom   = 1'b0;
        exp_addrs     = '{default: '0};
        aim_reads('0, '0, '0);
        exp_prog_addr = '0;
        exp_prog_data = '0;
        exp_prog_mask = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        step();
        assert (!sdram_req && !prog_we && !prom_we)
            else report_event("outputs not idle after reset");

        downloading = 1'b1;
        step();
        load_byte(25'h0008000);
        load_byte(25'h0008013);
        load_byte(25'h000a5e7);
        load_byte(25'h000bffe);
        load_byte(25'h000c000);
        load_byte(25'h000c039);
        load_byte(25'h0012345);
        load_byte(25'h001bfff);
        end_test("tile and sprite swizzle");

        load_byte(25'h0000002);
        load_byte(25'h0003ab1);
        load_byte(25'h001c000);
        load_byte(25'h001c0ff);
        end_test("PROM and plain writes");
        downloading = 1'b0;
        step();

        aim_reads(15'h1235, 14'h0123, 13'h0456);
        expect_single(main_word_addr(15'h1235));
        run_reads(3'b001);
        check_requests(1);
        aim_reads(15'h1234, 14'h0123, 13'h0456);
        expect_single(main_word_addr(15'h1234));
        run_reads(3'b001);
        check_requests(1);
        expect_single(obj_word_addr(14'h0123));
        run_reads(3'b010);
        check_requests(1);
        expect_single(scr_word_addr(13'h0456));
        run_reads(3'b100);
        check_requests(1);
        end_test("single slot reads");

        // Same addresses again, all cached
        req_base   = req_count;
        expect_hit = 1'b1;
        main_cs    = 1'b1;
        obj_cs     = 1'b1;
        scr_cs     = 1'b1;
        step();
        step();
        main_cs    = 1'b0;
        obj_cs     = 1'b0;
        scr_cs     = 1'b0;
        expect_hit = 1'b0;
        check_requests(0);
        end_test("cache hits");

        aim_reads(15'h2f01, 14'h1abc, 13'h1fff);
        exp_addrs[0] = main_word_addr(15'h2f01);
        exp_addrs[1] = obj_word_addr(14'h1abc);
        exp_addrs[2] = scr_word_addr(13'h1fff);
        req_base     = req_count;
        run_reads(3'b111);
        check_requests(3);
        end_test("fixed priority");

        downloading = 1'b1;
        repeat (3) step();
        downloading = 1'b0;
        step();
        expect_single(scr_word_addr(13'h1fff));
        run_reads(3'b100);
        check_requests(1);
        end_test("download invalidates cache");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/rom_pkg.sv
verilog/dwnld_decode.sv
verilog/rom_req_arbiter.sv
verilog/rom_slot_cache.sv
verilog/rom_subsys_top.sv
sim/sdram_model.sv
sim/tb_rom_subsys.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' verilog.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_rom_subsys: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_rom_subsys -f verilog.f

run: obj_dir/Vtb_rom_subsys
	./obj_dir/Vtb_rom_subsys | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
